// File: design/riscv_consts.svh
// Core data width, integer register count and reset program counter
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

////////////////////
// Datapath

// Data and address width
`define XLEN 32

// Integer registers, 5-bit index
`define RF_REGS 32

////////////////////
// Reset state

// Address of the first accepted instruction
`define PC_INIT 32'h0000_0200

`endif

// File: design/riscv_pkg.sv
// Package with ALU operation enum, major opcodes and instruction word views
package riscv_pkg;

  // Operations carried from decode to execute
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB   // LUI, operand B straight through
  } alu_op_t;

  // Major opcodes handled by this core
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  ////////////////////
  // Instruction word

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  // Same 32 bits, view picked by opcode
  typedef union packed {
    r_type_t r_type;
    i_type_t i_type;
    u_type_t u_type;
  } instr_u;

endpackage

// File: design/riscv_rf.sv
// Integer register file, two combinational read ports and one write port
`include "riscv_consts.svh"

module riscv_rf (
  input  logic              clk,
  input  logic              rst,

  // Read ports
  input  logic [4:0]        rf_src1,
  input  logic [4:0]        rf_src2,
  output logic [`XLEN-1:0]  rf_srcv1,
  output logic [`XLEN-1:0]  rf_srcv2,

  // Write port
  input  logic              rf_we,
  input  logic [4:0]        rf_dst,
  input  logic [`XLEN-1:0]  rf_dstv
);

  logic [`XLEN-1:0] regs [`RF_REGS];

  ////////////////////
  // Write

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // All registers start at zero
      for (int i = 0; i < `RF_REGS; i++)
        regs[i] <= '0;
    end
    else if (rf_we && rf_dst != 5'd0)
    begin
      // x0 stays zero, writes to it dropped
      regs[rf_dst] <= rf_dstv;
    end
  end

  ////////////////////
  // Read

  // x0 reads zero regardless of array content
  assign rf_srcv1 = (rf_src1 == 5'd0) ? '0 : regs[rf_src1];
  assign rf_srcv2 = (rf_src2 == 5'd0) ? '0 : regs[rf_src2];

endmodule

// File: design/riscv_id.sv
// Program counter, decoder, operand forwarding and decode stage register
`include "riscv_consts.svh"

module riscv_id import riscv_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // Instruction stream
  input  logic [31:0]       instr,
  input  logic              instr_valid,
  output logic              instr_ready,

  input  logic              stall,

  // Register file reads
  output logic [4:0]        rf_src1,
  output logic [4:0]        rf_src2,
  input  logic [`XLEN-1:0]  rf_srcv1,
  input  logic [`XLEN-1:0]  rf_srcv2,

  // Forward from execute
  input  logic              fwd_ex_valid,
  input  logic [4:0]        fwd_ex_dst,
  input  logic [`XLEN-1:0]  fwd_ex_r,

  // Forward from retire register
  input  logic              wb_valid,
  input  logic              wb_we,
  input  logic [4:0]        wb_dst,
  input  logic [`XLEN-1:0]  wb_r,

  // Decode stage register
  output logic              id_valid,
  output logic [`XLEN-1:0]  id_pc,
  output logic [31:0]       id_instr,
  output alu_op_t           id_op,
  output logic [`XLEN-1:0]  id_opa,
  output logic [`XLEN-1:0]  id_opb,
  output logic [4:0]        id_dst,
  output logic              id_we,
  output logic              id_illegal
);

  instr_u           iw;
  logic [`XLEN-1:0] pc;
  logic [`XLEN-1:0] src1_v;
  logic [`XLEN-1:0] src2_v;
  logic [`XLEN-1:0] imm;
  alu_op_t          dec_op;
  logic             use_imm;
  logic             zero_a;
  logic             illegal;

  assign iw          = instr;
  assign instr_ready = ~stall;

  ////////////////////
  // Operand forwarding

  assign rf_src1 = iw.r_type.rs1;
  assign rf_src2 = iw.r_type.rs2;

  // Execute result first, then retire register, then register file
  assign src1_v = (rf_src1 == 5'd0) ? '0 :
                  (fwd_ex_valid && fwd_ex_dst == rf_src1) ? fwd_ex_r :
                  (wb_valid && wb_we && wb_dst == rf_src1) ? wb_r : rf_srcv1;
  assign src2_v = (rf_src2 == 5'd0) ? '0 :
                  (fwd_ex_valid && fwd_ex_dst == rf_src2) ? fwd_ex_r :
                  (wb_valid && wb_we && wb_dst == rf_src2) ? wb_r : rf_srcv2;

  ////////////////////
  // Decode

  always_comb
  begin
    dec_op  = ALU_ADD;
    // Sign-extended I immediate unless overridden
    imm     = {{(`XLEN-12){iw.i_type.imm12[11]}}, iw.i_type.imm12};
    use_imm = 1'b0;
    zero_a  = 1'b0;
    illegal = 1'b0;
    case (iw.r_type.opcode)
      OPC_OP:
        case ({iw.r_type.funct7, iw.r_type.funct3})
          {7'h00, 3'b000}: dec_op = ALU_ADD;
          {7'h20, 3'b000}: dec_op = ALU_SUB;
          {7'h00, 3'b001}: dec_op = ALU_SLL;
          {7'h00, 3'b010}: dec_op = ALU_SLT;
          {7'h00, 3'b011}: dec_op = ALU_SLTU;
          {7'h00, 3'b100}: dec_op = ALU_XOR;
          {7'h00, 3'b101}: dec_op = ALU_SRL;
          {7'h20, 3'b101}: dec_op = ALU_SRA;
          {7'h00, 3'b110}: dec_op = ALU_OR;
          {7'h00, 3'b111}: dec_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      OPC_OP_IMM:
      begin
        use_imm = 1'b1;
        case (iw.i_type.funct3)
          3'b000: dec_op = ALU_ADD;
          3'b010: dec_op = ALU_SLT;
          3'b011: dec_op = ALU_SLTU;
          3'b100: dec_op = ALU_XOR;
          3'b110: dec_op = ALU_OR;
          3'b111: dec_op = ALU_AND;
          3'b001:
          begin
            // SLLI, upper imm bits must be clear
            dec_op  = ALU_SLL;
            imm     = {{(`XLEN-5){1'b0}}, iw.i_type.imm12[4:0]};
            illegal = (iw.i_type.imm12[11:5] != 7'h00);
          end
          default:
          begin
            // SRLI or SRAI picked by imm[10]
            dec_op  = iw.i_type.imm12[10] ? ALU_SRA : ALU_SRL;
            imm     = {{(`XLEN-5){1'b0}}, iw.i_type.imm12[4:0]};
            illegal = (iw.i_type.imm12[11:5] != 7'h00) &&
                      (iw.i_type.imm12[11:5] != 7'h20);
          end
        endcase
      end
      OPC_LUI:
      begin
        dec_op  = ALU_PASSB;
        imm     = {iw.u_type.imm20, 12'h000};
        use_imm = 1'b1;
        zero_a  = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  ////////////////////
  // PC and stage register

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc       <= `PC_INIT;
      id_valid <= 1'b0;
    end
    else if (!stall)
    begin
      // Bubble when nothing offered
      id_valid <= instr_valid;
      if (instr_valid)
        pc <= pc + `XLEN'd4;
    end
  end

  // Payload loads only on a transfer
  always_ff @(posedge clk)
  begin
    if (!stall && instr_valid)
    begin
      id_pc      <= pc;
      id_instr   <= instr;
      id_op      <= dec_op;
      id_opa     <= zero_a ? '0 : src1_v;
      id_opb     <= use_imm ? imm : src2_v;
      id_dst     <= iw.r_type.rd;
      id_we      <= ~illegal;
      id_illegal <= illegal;
    end
  end

endmodule

// File: design/riscv_ex.sv
// ALU, retire register, retire stream and stall generation
`include "riscv_consts.svh"

module riscv_ex import riscv_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // Decode stage register
  input  logic              id_valid,
  input  logic [`XLEN-1:0]  id_pc,
  input  logic [31:0]       id_instr,
  input  alu_op_t           id_op,
  input  logic [`XLEN-1:0]  id_opa,
  input  logic [`XLEN-1:0]  id_opb,
  input  logic [4:0]        id_dst,
  input  logic              id_we,
  input  logic              id_illegal,

  // Forward path to decode
  output logic              fwd_ex_valid,
  output logic [4:0]        fwd_ex_dst,
  output logic [`XLEN-1:0]  fwd_ex_r,

  // Retire register forward
  output logic              wb_valid,
  output logic              wb_we,
  output logic [4:0]        wb_dst,
  output logic [`XLEN-1:0]  wb_r,

  // Register file write
  output logic              rf_we,
  output logic [4:0]        rf_dst,
  output logic [`XLEN-1:0]  rf_dstv,

  // Retire stream
  input  logic              retire_ready,
  output logic              retire_valid,
  output logic [`XLEN-1:0]  retire_pc,
  output logic [31:0]       retire_instr,
  output logic [4:0]        retire_rd,
  output logic [`XLEN-1:0]  retire_value,
  output logic              retire_illegal,

  output logic              stall
);

  logic [`XLEN-1:0] alu_r;
  logic [4:0]       shamt;

  ////////////////////
  // ALU

  // Shifts use low 5 bits of B only
  assign shamt = id_opb[4:0];

  always_comb
  begin
    case (id_op)
      ALU_ADD:  alu_r = id_opa + id_opb;
      ALU_SUB:  alu_r = id_opa - id_opb;
      ALU_SLL:  alu_r = id_opa << shamt;
      ALU_SLT:  alu_r = {{(`XLEN-1){1'b0}}, $signed(id_opa) < $signed(id_opb)};
      ALU_SLTU: alu_r = {{(`XLEN-1){1'b0}}, id_opa < id_opb};
      ALU_XOR:  alu_r = id_opa ^ id_opb;
      ALU_SRL:  alu_r = id_opa >> shamt;
      ALU_SRA:  alu_r = $unsigned($signed(id_opa) >>> shamt);
      ALU_OR:   alu_r = id_opa | id_opb;
      ALU_AND:  alu_r = id_opa & id_opb;
      default:  alu_r = id_opb;    // pass B for LUI
    endcase
  end

  // Fresh result back to decode
  assign fwd_ex_valid = id_valid & id_we;
  assign fwd_ex_dst   = id_dst;
  assign fwd_ex_r     = alu_r;

  ////////////////////
  // Retire register

  // Full and not taken this cycle
  assign stall = retire_valid & ~retire_ready;

  always_ff @(posedge clk)
  begin
    if (rst)
      retire_valid <= 1'b0;
    else if (!stall)
      retire_valid <= id_valid;
  end

  always_ff @(posedge clk)
  begin
    if (!stall && id_valid)
    begin
      retire_pc      <= id_pc;
      retire_instr   <= id_instr;
      // Illegal words retire as rd zero, value zero
      retire_rd      <= id_illegal ? 5'd0 : id_dst;
      retire_value   <= id_illegal ? '0 : alu_r;
      retire_illegal <= id_illegal;
      wb_we          <= id_we;
    end
  end

  assign wb_valid = retire_valid;
  assign wb_dst   = retire_rd;
  assign wb_r     = retire_value;

  // One write per instruction, on the retire handshake
  assign rf_we   = retire_valid & retire_ready & wb_we;
  assign rf_dst  = retire_rd;
  assign rf_dstv = retire_value;

endmodule

// File: design/riscv_core.sv
// Core top level joining decoder, executor and integer register file
`include "riscv_consts.svh"

module riscv_core import riscv_pkg::*; (
  input  logic              clk,
  input  logic              rst,

  // Instruction stream
  input  logic [31:0]       instr,
  input  logic              instr_valid,
  output logic              instr_ready,

  // Retire stream
  output logic              retire_valid,
  input  logic              retire_ready,
  output logic [`XLEN-1:0]  retire_pc,
  output logic [31:0]       retire_instr,
  output logic [4:0]        retire_rd,
  output logic [`XLEN-1:0]  retire_value,
  output logic              retire_illegal
);

  ////////////////////
  // Stage signals

  // Decode stage register
  logic              id_valid;
  logic [`XLEN-1:0]  id_pc;
  logic [31:0]       id_instr;
  alu_op_t           id_op;
  logic [`XLEN-1:0]  id_opa;
  logic [`XLEN-1:0]  id_opb;
  logic [4:0]        id_dst;
  logic              id_we;
  logic              id_illegal;

  // Forwarding
  logic              fwd_ex_valid;
  logic [4:0]        fwd_ex_dst;
  logic [`XLEN-1:0]  fwd_ex_r;
  logic              wb_valid;
  logic              wb_we;
  logic [4:0]        wb_dst;
  logic [`XLEN-1:0]  wb_r;

  // Register file
  logic [4:0]        rf_src1;
  logic [4:0]        rf_src2;
  logic [`XLEN-1:0]  rf_srcv1;
  logic [`XLEN-1:0]  rf_srcv2;
  logic              rf_we;
  logic [4:0]        rf_dst;
  logic [`XLEN-1:0]  rf_dstv;

  // Back-pressure from retire stream
  logic              stall;

  ////////////////////
  // Units

  // Decode, holds PC
  riscv_id id_unit ( .* );

  // Execute and retire
  riscv_ex ex_unit ( .* );

  // Integer registers
  riscv_rf int_rf ( .* );

endmodule

// File: verif/riscv_core_tb.sv
// Testbench with clock, reset, random program stimulus, reference model and retire checker
`include "riscv_consts.svh"

module riscv_core_tb import riscv_pkg::*; ();

  localparam int ACCEPT_LIMIT = 200;
  localparam int DRAIN_LIMIT  = 4000;

  logic              clk;
  logic              rst;
  logic [31:0]       instr;
  logic              instr_valid;
  logic              instr_ready;
  logic              retire_valid;
  logic              retire_ready;
  logic [`XLEN-1:0]  retire_pc;
  logic [31:0]       retire_instr;
  logic [4:0]        retire_rd;
  logic [`XLEN-1:0]  retire_value;
  logic              retire_illegal;

  integer            seed = 32'h61e5_f78f;
  int                err_cnt = 0;
  int                tmo_cnt = 0;
  int                cyc = 0;
  bit                drop_en = 1'b0;
  bit                lat_check = 1'b1;
  bit                ready_pat [1024];
  // Bit 32 asks for an idle cycle before the word
  logic [32:0]       prog_q [$];
  logic [31:0]       exp_q [$];
  int                acc_q [$];
  logic [`XLEN-1:0]  model_regs [`RF_REGS];
  logic [`XLEN-1:0]  model_pc;

  riscv_core i_riscv_core ( .* );

  ////////////////////
  // Clock and back-pressure

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // Pattern filled at time zero, indexed by cycle
  initial
  begin
    retire_ready = 1'b1;
    forever
    begin
      @(posedge clk);
      #1;
      retire_ready = drop_en ? ready_pat[cyc % 1024] : 1'b1;
    end
  end

  ////////////////////
  // Instruction encoding

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, OPC_LUI};
  endfunction

  // Registers limited to x0..x15 so hazards come often
  function automatic logic [31:0] gen_legal();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    r   = $random(seed);
    f3  = r[14:12];
    rd  = {1'b0, r[10:7]};
    rs1 = {1'b0, r[18:15]};
    rs2 = {1'b0, r[23:20]};
    case (r[1:0])
      2'd1:
        if (f3 == 3'b001)
          return enc_i({7'h00, r[24:20]}, rs1, f3, rd);
        else if (f3 == 3'b101)
          return enc_i({r[30] ? 7'h20 : 7'h00, r[24:20]}, rs1, f3, rd);
        else
          return enc_i(r[31:20], rs1, f3, rd);
      2'd2: return enc_lui(r[31:12], rd);
      default:
        return enc_r((r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                     rs2, rs1, f3, rd);
    endcase
  endfunction

  function automatic logic [31:0] gen_illegal();
    logic [31:0] r;
    r = $random(seed);
    case (r[1:0])
      2'd0: return {r[31:7], 7'b0000011};   // load
      2'd1: return enc_r(7'h01, r[24:20], r[19:15], r[14:12], r[11:7]);
      2'd2: return enc_i({7'h20, r[24:20]}, r[19:15], 3'b001, r[11:7]);
      default: return enc_i({7'h10, r[24:20]}, r[19:15], 3'b101, r[11:7]);
    endcase
  endfunction

  ////////////////////
  // Reference model

  function automatic void model_exec(input logic [31:0] w, output logic [`XLEN-1:0] pc,
                                     output logic [4:0] rd, output logic [`XLEN-1:0] val,
                                     output logic ill);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    logic [4:0]       sh;
    a        = model_regs[w[19:15]];
    b        = model_regs[w[24:20]];
    imm      = {{20{w[31]}}, w[31:20]};
    sh       = w[24:20];
    pc       = model_pc;
    model_pc = model_pc + 4;
    ill      = 1'b0;
    val      = '0;
    if (w[6:0] == OPC_OP && w[31:25] == 7'h20)
    begin
      // Only SUB and SRA use the alternate funct7
      if (w[14:12] == 3'b000)
        val = a - b;
      else if (w[14:12] == 3'b101)
        val = $signed(a) >>> b[4:0];
      else
        ill = 1'b1;
    end
    else if (w[6:0] == OPC_OP && w[31:25] == 7'h00)
      case (w[14:12])
        3'b000:  val = a + b;
        3'b001:  val = a << b[4:0];
        3'b010:  val = ($signed(a) < $signed(b)) ? 1 : 0;
        3'b011:  val = (a < b) ? 1 : 0;
        3'b100:  val = a ^ b;
        3'b101:  val = a >> b[4:0];
        3'b110:  val = a | b;
        default: val = a & b;
      endcase
    else if (w[6:0] == OPC_OP_IMM)
      case (w[14:12])
        3'b000: val = a + imm;
        3'b010: val = ($signed(a) < $signed(imm)) ? 1 : 0;
        3'b011: val = (a < imm) ? 1 : 0;
        3'b100: val = a ^ imm;
        3'b110: val = a | imm;
        3'b111: val = a & imm;
        3'b001:
          if (w[31:25] == 7'h00)
            val = a << sh;
          else
            ill = 1'b1;
        default:
          if (w[31:25] == 7'h00)
            val = a >> sh;
          else if (w[31:25] == 7'h20)
            val = $signed(a) >>> sh;
          else
            ill = 1'b1;
      endcase
    else if (w[6:0] == OPC_LUI)
      val = {w[31:12], 12'h000};
    else
      ill = 1'b1;
    // Illegal words change no state
    rd = ill ? 5'd0 : w[11:7];
    if (ill)
      val = '0;
    else if (rd != 5'd0)
      model_regs[rd] = val;
  endfunction

  ////////////////////
  // Stimulus

  task automatic queue_word(input logic gap, input logic [31:0] w);
    prog_q.push_back({gap, w});
  endtask

  // Each word reads the previous rd, x0 write and illegal word mid-chain
  task automatic push_chain();
    queue_word(1'b0, enc_i(12'h123, 5'd0, 3'b000, 5'd1));
    queue_word(1'b0, enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    queue_word(1'b0, enc_r(7'h00, 5'd1, 5'd2, 3'b100, 5'd3));
    queue_word(1'b0, enc_r(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
    queue_word(1'b0, enc_i(12'h005, 5'd4, 3'b000, 5'd0));
    queue_word(1'b0, enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd5));
    queue_word(1'b0, enc_lui(20'h80001, 5'd6));
    queue_word(1'b0, enc_i(12'hfff, 5'd6, 3'b000, 5'd6));
    queue_word(1'b0, enc_i({7'h20, 5'd4}, 5'd6, 3'b101, 5'd7));
    queue_word(1'b0, enc_r(7'h00, 5'd6, 5'd7, 3'b010, 5'd8));
    queue_word(1'b0, enc_r(7'h00, 5'd6, 5'd7, 3'b011, 5'd9));
    queue_word(1'b0, enc_r(7'h00, 5'd9, 5'd6, 3'b101, 5'd10));
    queue_word(1'b0, 32'h0000_2503);
    queue_word(1'b0, enc_r(7'h00, 5'd10, 5'd10, 3'b000, 5'd11));
  endtask

  // Entered and left just after a rising edge
  task automatic offer(input logic [31:0] w);
    int waited;
    bit done;
    waited      = 0;
    done        = 1'b0;
    instr       = w;
    instr_valid = 1'b1;
    while (!done)
    begin
      @(negedge clk);
      if (instr_ready)
      begin
        // Handshake on the coming edge, count taken before it like the checker
        exp_q.push_back(w);
        acc_q.push_back(cyc);
        done = 1'b1;
      end
      else if (++waited > ACCEPT_LIMIT)
      begin
        tmo_cnt++;
        $display("Timeout waiting for instr_ready to accept word %h", w);
        done = 1'b1;
      end
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b0;
  endtask

  task automatic run_prog();
    logic [32:0] e;
    while (prog_q.size() != 0 && tmo_cnt == 0)
    begin
      e = prog_q.pop_front();
      if (e[32])
      begin
        // Junk on the bus while idle
        instr = $random(seed);
        @(posedge clk);
        #1;
      end
      offer(e[31:0]);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && tmo_cnt == 0)
    begin
      @(posedge clk);
      #1;
      if (++waited > DRAIN_LIMIT)
      begin
        tmo_cnt++;
        $display("Timeout waiting for %0d instructions to retire", exp_q.size());
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("ERR %s expected %h got %h", name, exp, act);
    end
  endtask

  ////////////////////
  // Retire checker

  // Falling edge, all outputs settled
  initial
  begin
    logic [31:0]      w;
    logic [`XLEN-1:0] e_pc;
    logic [`XLEN-1:0] e_val;
    logic [4:0]       e_rd;
    logic             e_ill;
    int               acc;
    bit               held;
    logic [`XLEN-1:0] h_pc;
    logic [31:0]      h_instr;
    logic [4:0]       h_rd;
    logic [`XLEN-1:0] h_val;
    logic             h_ill;
    held = 1'b0;
    forever
    begin
      @(negedge clk);
      if (!rst)
      begin
        // Not ready exactly while the record is blocked
        compare_field("instr_ready", {31'b0, ~(retire_valid & ~retire_ready)},
                      {31'b0, instr_ready});
        if (held)
        begin
          compare_field("retire_valid", 32'd1, {31'b0, retire_valid});
          compare_field("retire_pc", h_pc, retire_pc);
          compare_field("retire_instr", h_instr, retire_instr);
          compare_field("retire_rd", {27'b0, h_rd}, {27'b0, retire_rd});
          compare_field("retire_value", h_val, retire_value);
          compare_field("retire_illegal", {31'b0, h_ill}, {31'b0, retire_illegal});
        end
        if (retire_valid && retire_ready)
        begin
          assert (exp_q.size() != 0)
          else
          begin
            err_cnt++;
            $display("Retire handshake with no instruction outstanding");
          end
          if (exp_q.size() != 0)
          begin
            w   = exp_q.pop_front();
            acc = acc_q.pop_front();
            model_exec(w, e_pc, e_rd, e_val, e_ill);
            compare_field("retire_pc", e_pc, retire_pc);
            compare_field("retire_instr", w, retire_instr);
            compare_field("retire_rd", {27'b0, e_rd}, {27'b0, retire_rd});
            compare_field("retire_value", e_val, retire_value);
            compare_field("retire_illegal", {31'b0, e_ill}, {31'b0, retire_illegal});
            if (lat_check)
            begin
              assert (cyc == acc + 2)
              else
              begin
                err_cnt++;
                $display("Retire of pc %h came %0d edges after acceptance instead of 2",
                         retire_pc, cyc - acc);
              end
            end
          end
        end
        held    = retire_valid && !retire_ready;
        h_pc    = retire_pc;
        h_instr = retire_instr;
        h_rd    = retire_rd;
        h_val   = retire_value;
        h_ill   = retire_illegal;
      end
    end
  end

  ////////////////////
  // Test sequence

  initial
  begin
    rst         = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    model_pc    = `PC_INIT;
    for (int i = 0; i < `RF_REGS; i++)
      model_regs[i] = '0;
    // Ready high three cycles in four
    for (int i = 0; i < 1024; i++)
      ready_pat[i] = ($random(seed) & 3) != 0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    compare_field("instr_ready", 32'd1, {31'b0, instr_ready});
    compare_field("retire_valid", 32'd0, {31'b0, retire_valid});
    @(posedge clk);
    #1;

    // Chains and random mix at full rate
    push_chain();
    for (int i = 0; i < 300; i++)
      queue_word(1'b0, (($random(seed) & 15) == 0) ? gen_illegal() : gen_legal());
    run_prog();
    wait_drain();

    // Random back-pressure and input gaps
    lat_check = 1'b0;
    drop_en   = 1'b1;
    push_chain();
    for (int i = 0; i < 250; i++)
      queue_word(($random(seed) & 7) == 0,
                 (($random(seed) & 15) == 0) ? gen_illegal() : gen_legal());
    run_prog();
    wait_drain();

    // Full rate again, pipeline empty
    drop_en = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    lat_check = 1'b1;
    push_chain();
    for (int i = 0; i < 100; i++)
      queue_word(1'b0, gen_legal());
    run_prog();
    wait_drain();

    $display("Errors: %0d, timeouts: %0d", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/riscv_pkg.sv
design/riscv_rf.sv
design/riscv_id.sv
design/riscv_ex.sv
design/riscv_core.sv
verif/riscv_core_tb.sv

// File: Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - design
    files:
      - design/riscv_pkg.sv
      - design/riscv_rf.sv
      - design/riscv_id.sv
      - design/riscv_ex.sv
      - design/riscv_core.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verif/riscv_core_tb.sv
